// File: tb.f
src/goomba_cfg_pkg.sv
src/goomba_types_pkg.sv
src/frame_timer.sv
src/goomba_fsm.sv
src/goomba_motion.sv
src/goomba_sprite.sv
src/goomba_top.sv
dv/goomba_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the goomba testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module goomba_tb -o goomba_sim \
    && ./obj_dir/goomba_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: dv/goomba_tb.sv
`timescale 1ns/1ps
`default_nettype none

module goomba_tb;

    typedef goomba_types_pkg::coord_t coord_t;
    typedef goomba_types_pkg::pixel_t pixel_t;

    // The tests run roughly 330 frames of 9 cycles each.
    localparam int     MAX_CYCLES = 20000;
    localparam coord_t HOME_X     = coord_t'(400);
    localparam coord_t X_LIMIT    = coord_t'(1000);
    localparam coord_t STEP       = coord_t'(goomba_cfg_pkg::X_STEP);
    localparam coord_t SPRITE     = coord_t'(goomba_cfg_pkg::SPRITE_SIZE);
    localparam coord_t GROUND     = coord_t'(goomba_cfg_pkg::Y_GROUND);
    localparam int     DECIDE     = int'(goomba_cfg_pkg::DECIDE_FRAMES);
    localparam int     DEATH      = int'(goomba_cfg_pkg::DEATH_FRAMES);

    logic                          Clk;
    logic                          arst_n;
    logic                          frame_clk;
    coord_t                        draw_x;
    coord_t                        draw_y;
    coord_t                        scroll;
    goomba_types_pkg::player_t     mario;
    goomba_types_pkg::player_t     luigi;
    logic                          stomped;
    goomba_types_pkg::sprite_art_t art;
    coord_t                        goomba_x;
    coord_t                        goomba_y;
    logic                          goomba_hit;
    pixel_t                        pixel;

    int seed;
    int cycle_count;
    int error_count;
    int errors_at_start;
    int test_count;
    int failed_tests;

    goomba_top #(
        .home_x  (HOME_X),
        .x_limit (X_LIMIT)
    ) i_goomba_top (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .frame_clk  (frame_clk),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .scroll     (scroll),
        .mario      (mario),
        .luigi      (luigi),
        .stomped    (stomped),
        .art        (art),
        .goomba_x   (goomba_x),
        .goomba_y   (goomba_y),
        .goomba_hit (goomba_hit),
        .pixel      (pixel)
    );

    always #5 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the tests did not finish.", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        assert (got == exp)
        else
        begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp);
        assert (got == exp)
        else
        begin
            $display("MISMATCH t=%0t pixel got %h expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("ERROR t=%0t %s", $time, what);
            error_count++;
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - errors_at_start;
        test_count++;
        if (errs == 0)
            $display("test %s: passed", name);
        else
        begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic apply_reset();
        @(posedge Clk);
        arst_n    <= 1'b0;
        frame_clk <= 1'b0;
        stomped   <= 1'b0;
        repeat (3) @(posedge Clk);
        arst_n <= 1'b1;
        @(negedge Clk);
    endtask

    task automatic set_scene(input logic m_alive, input int m_x, input logic l_alive,
                             input int l_x, input int sc);
        @(posedge Clk);
        mario.alive <= m_alive;
        mario.x     <= coord_t'(m_x);
        luigi.alive <= l_alive;
        luigi.x     <= coord_t'(l_x);
        scroll      <= coord_t'(sc);
    endtask

    task automatic set_stomped(input logic value);
        @(posedge Clk);
        stomped <= value;
    endtask

    // One video frame of 2 high and 6 low cycles with results settled at the end.
    task automatic frame_pulse();
        @(posedge Clk);
        frame_clk <= 1'b1;
        repeat (2) @(posedge Clk);
        frame_clk <= 1'b0;
        repeat (6) @(posedge Clk);
        @(negedge Clk);
    endtask

    // Walks until the heading flips, then checks a few steady steps.
    task automatic expect_turn(input logic to_left, input string what);
        coord_t prev_x;
        int     n;
        n = 0;
        do
        begin
            prev_x = goomba_x;
            frame_pulse();
            n++;
        end
        while ((to_left ? goomba_x > prev_x : goomba_x < prev_x) && n <= DECIDE);
        check_true(goomba_x == (to_left ? prev_x - STEP : prev_x + STEP), what);
        repeat (3)
        begin
            prev_x = goomba_x;
            frame_pulse();
            check_coord("goomba_x", goomba_x, to_left ? prev_x - STEP : prev_x + STEP);
        end
    endtask

    function automatic logic expected_hit(input int bx, input int by, input int sc,
                                          input int gx, input logic shown);
        int wx;
        wx = bx + sc;                                     // Beam in world space.
        return shown && wx > gx && wx < gx + int'(SPRITE) &&
               by > int'(GROUND) && by < int'(GROUND) + int'(SPRITE);
    endfunction

    task automatic hit_case(input int bx, input int by, input int sc, input int gx,
                            input logic shown);
        logic exp_hit;
        @(posedge Clk);
        draw_x <= coord_t'(bx);
        draw_y <= coord_t'(by);
        scroll <= coord_t'(sc);
        @(negedge Clk);
        exp_hit = expected_hit(bx, by, sc, gx, shown);
        assert (goomba_hit == exp_hit)
        else
        begin
            $display("MISMATCH t=%0t goomba_hit got %0b expected %0b (beam %0d,%0d scroll %0d)",
                     $time, goomba_hit, exp_hit, bx, by, sc);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        start_test();
        set_scene(1'b0, 0, 1'b0, 0, 0);
        apply_reset();
        check_coord("goomba_x", goomba_x, HOME_X);
        check_coord("goomba_y", goomba_y, GROUND);
        @(negedge Clk);
        check_pixel(pixel, art.walk_a);
        end_test("reset");
    endtask

    task automatic test_walk();
        coord_t exp_x;
        start_test();
        set_scene(1'b0, 0, 1'b0, 0, 0);
        apply_reset();
        exp_x = HOME_X;
        for (int i = 1; i <= DECIDE; i++)
        begin
            frame_pulse();
            exp_x = exp_x - STEP;
            check_coord("goomba_x", goomba_x, exp_x);
            check_pixel(pixel, (i % 2 == 1) ? art.walk_b : art.walk_a);
        end
        end_test("walk");
    endtask

    task automatic test_chase();
        start_test();
        set_scene(1'b0, 0, 1'b1, 600, 0);
        apply_reset();
        expect_turn(1'b0, "goomba did not turn right toward luigi");
        set_scene(1'b1, 100, 1'b1, 460, 0);               // Mario is the farther one.
        expect_turn(1'b1, "goomba did not turn left toward the farther player");
        set_scene(1'b1, 100, 1'b1, 1000, 0);              // Now luigi is farther.
        expect_turn(1'b0, "goomba did not turn right toward the farther player");
        end_test("chase");
    endtask

    task automatic test_edges();
        coord_t prev_x;
        logic   turned;
        int     n;
        int     max_frames;
        start_test();
        set_scene(1'b0, 0, 1'b0, 0, 0);
        apply_reset();
        frame_pulse();
        check_coord("goomba_x", goomba_x, HOME_X - STEP);
        set_scene(1'b0, 0, 1'b0, 0, int'(HOME_X));        // Screen edge now past the goomba.
        frame_pulse();
        check_coord("goomba_x", goomba_x, HOME_X);

        set_scene(1'b0, 0, 1'b1, 1023, 0);
        max_frames = (int'(X_LIMIT) - int'(SPRITE) - int'(HOME_X)) / int'(STEP) + 2 * DECIDE;
        turned = 1'b0;
        n = 0;
        while (!turned && n < max_frames)
        begin
            prev_x = goomba_x;
            frame_pulse();
            n++;
            check_true(goomba_x <= X_LIMIT, "goomba_x went past x_limit");
            if (goomba_x < prev_x)
            begin
                turned = 1'b1;
                check_coord("goomba_x before the turn", prev_x, X_LIMIT - SPRITE);
            end
        end
        check_true(turned, "goomba did not turn left at the right limit");
        repeat (2 * DECIDE)
        begin
            frame_pulse();
            check_true(goomba_x <= X_LIMIT, "goomba_x went past x_limit");
        end
        end_test("edges");
    endtask

    task automatic test_stomp();
        int n;
        start_test();
        set_scene(1'b0, 0, 1'b0, 0, 0);
        apply_reset();
        frame_pulse();
        set_stomped(1'b1);
        frame_pulse();
        set_stomped(1'b0);
        check_coord("goomba_x", goomba_x, HOME_X - STEP);
        check_pixel(pixel, art.squashed);
        n = 0;
        while (goomba_x != '0 && n <= DEATH)
        begin
            frame_pulse();
            n++;
            if (goomba_x != '0)
            begin
                check_coord("goomba_x", goomba_x, HOME_X - STEP);
                check_pixel(pixel, art.squashed);
            end
        end
        check_true(n >= DEATH, "goomba vanished before the squash time ran out");
        check_true(goomba_x == '0, "goomba did not vanish after the squash time");
        repeat (3)
        begin
            check_coord("goomba_x", goomba_x, '0);
            check_pixel(pixel, goomba_cfg_pkg::SKY_COLOR);
            frame_pulse();
        end
        end_test("stomp");
    endtask

    // Starts with the goomba gone at x = 0, as the stomp test leaves it.
    task automatic test_hit();
        int bx;
        int by;
        int sc;
        start_test();
        hit_case(10, 400, 0, 0, 1'b0);
        hit_case(16, 390, 0, 0, 1'b0);
        set_scene(1'b0, 0, 1'b0, 0, 0);
        apply_reset();
        hit_case(401, 385, 0, int'(HOME_X), 1'b1);
        hit_case(400, 385, 0, int'(HOME_X), 1'b1);
        hit_case(431, 415, 0, int'(HOME_X), 1'b1);
        hit_case(432, 400, 0, int'(HOME_X), 1'b1);
        hit_case(410, 384, 0, int'(HOME_X), 1'b1);
        hit_case(410, 416, 0, int'(HOME_X), 1'b1);
        hit_case(300, 400, 110, int'(HOME_X), 1'b1);
        hit_case(290, 400, 110, int'(HOME_X), 1'b1);
        repeat (24)
        begin
            bx = 330 + int'({$random(seed)} % 80);
            by = 370 + int'({$random(seed)} % 60);
            sc = int'({$random(seed)} % 64);
            hit_case(bx, by, sc, int'(HOME_X), 1'b1);
        end
        end_test("hit");
    endtask

    initial
    begin
        seed            = 32'h0d24_17e1;
        cycle_count     = 0;
        error_count     = 0;
        errors_at_start = 0;
        test_count      = 0;
        failed_tests    = 0;
        Clk             = 1'b0;
        arst_n          = 1'b0;
        frame_clk       = 1'b0;
        draw_x          = '0;
        draw_y          = '0;
        scroll          = '0;
        mario           = '0;
        luigi           = '0;
        stomped         = 1'b0;
        art.walk_a      = pixel_t'($random(seed));
        art.walk_b      = pixel_t'($random(seed));
        art.squashed    = pixel_t'($random(seed));

        test_reset();
        test_walk();
        test_chase();
        test_edges();
        test_stomp();
        test_hit();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/goomba_top.sv
`timescale 1ns/1ps
`default_nettype none

module goomba_top
#(
    parameter goomba_types_pkg::coord_t home_x  = goomba_types_pkg::coord_t'(400),
    parameter goomba_types_pkg::coord_t x_limit = goomba_types_pkg::coord_t'(1023)
)
(
    input  logic                          Clk,
    input  logic                          arst_n,
    input  logic                          frame_clk,
    input  goomba_types_pkg::coord_t      draw_x,
    input  goomba_types_pkg::coord_t      draw_y,
    input  goomba_types_pkg::coord_t      scroll,
    input  goomba_types_pkg::player_t     mario,
    input  goomba_types_pkg::player_t     luigi,
    input  logic                          stomped,
    input  goomba_types_pkg::sprite_art_t art,
    output goomba_types_pkg::coord_t      goomba_x,
    output goomba_types_pkg::coord_t      goomba_y,
    output logic                          goomba_hit,
    output goomba_types_pkg::pixel_t      pixel
);

    logic                        frame_tick;
    logic                        decide_due;
    logic                        death_done;
    logic                        count_clr;
    goomba_types_pkg::steer_t    steer;
    goomba_types_pkg::move_cmd_t cmd;
    goomba_types_pkg::pose_t     pose;

    frame_timer i_frame_timer (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .frame_clk  (frame_clk),
        .count_clr  (count_clr),
        .frame_tick (frame_tick),
        .decide_due (decide_due),
        .death_done (death_done)
    );

    goomba_fsm i_goomba_fsm (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .frame_tick (frame_tick),
        .decide_due (decide_due),
        .death_done (death_done),
        .steer      (steer),
        .stomped    (stomped),
        .cmd        (cmd),
        .count_clr  (count_clr),
        .pose       (pose)
    );

    goomba_motion #(
        .home_x  (home_x),
        .x_limit (x_limit)
    ) i_goomba_motion (
        .Clk      (Clk),
        .arst_n   (arst_n),
        .cmd      (cmd),
        .scroll   (scroll),
        .mario    (mario),
        .luigi    (luigi),
        .steer    (steer),
        .goomba_x (goomba_x),
        .goomba_y (goomba_y)
    );

    goomba_sprite i_goomba_sprite (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .pose       (pose),
        .art        (art),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .scroll     (scroll),
        .goomba_x   (goomba_x),
        .goomba_y   (goomba_y),
        .goomba_hit (goomba_hit),
        .pixel      (pixel)
    );

endmodule

`default_nettype wire

// File: src/goomba_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module goomba_sprite
(
    input  logic                          Clk,
    input  logic                          arst_n,
    input  goomba_types_pkg::pose_t       pose,
    input  goomba_types_pkg::sprite_art_t art,
    input  goomba_types_pkg::coord_t      draw_x,
    input  goomba_types_pkg::coord_t      draw_y,
    input  goomba_types_pkg::coord_t      scroll,
    input  goomba_types_pkg::coord_t      goomba_x,
    input  goomba_types_pkg::coord_t      goomba_y,
    output logic                          goomba_hit,
    output goomba_types_pkg::pixel_t      pixel
);

    goomba_types_pkg::wide_coord_t world_x;
    goomba_types_pkg::wide_coord_t x_near;
    goomba_types_pkg::wide_coord_t x_far;
    goomba_types_pkg::wide_coord_t y_near;
    goomba_types_pkg::wide_coord_t y_far;
    goomba_types_pkg::wide_coord_t beam_y;

    ////////////////////////////////////////////////////////////////////////////
    // Beam hit test
    ////////////////////////////////////////////////////////////////////////////

    assign world_x = goomba_types_pkg::wide_coord_t'(draw_x) +
                     goomba_types_pkg::wide_coord_t'(scroll);   // Beam in world space.
    assign beam_y  = goomba_types_pkg::wide_coord_t'(draw_y);
    assign x_near  = goomba_types_pkg::wide_coord_t'(goomba_x);
    assign y_near  = goomba_types_pkg::wide_coord_t'(goomba_y);
    assign x_far   = x_near + goomba_types_pkg::wide_coord_t'(goomba_cfg_pkg::SPRITE_SIZE);
    assign y_far   = y_near + goomba_types_pkg::wide_coord_t'(goomba_cfg_pkg::SPRITE_SIZE);

    assign goomba_hit = (world_x > x_near) && (world_x < x_far) &&
                        (beam_y > y_near) && (beam_y < y_far) &&
                        (pose != goomba_types_pkg::HIDDEN);

    ////////////////////////////////////////////////////////////////////////////
    // Pixel select
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            pixel <= goomba_cfg_pkg::SKY_COLOR;
        else
        begin
            case (pose)
                goomba_types_pkg::GAIT_A:   pixel <= art.walk_a;
                goomba_types_pkg::GAIT_B:   pixel <= art.walk_b;
                goomba_types_pkg::SQUASHED: pixel <= art.squashed;
                default:                    pixel <= goomba_cfg_pkg::SKY_COLOR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/goomba_motion.sv
`timescale 1ns/1ps
`default_nettype none

module goomba_motion
#(
    parameter goomba_types_pkg::coord_t home_x  = goomba_types_pkg::coord_t'(400),
    parameter goomba_types_pkg::coord_t x_limit = goomba_types_pkg::coord_t'(1023)
)
(
    input  logic                          Clk,
    input  logic                          arst_n,
    input  goomba_types_pkg::move_cmd_t   cmd,
    input  goomba_types_pkg::coord_t      scroll,
    input  goomba_types_pkg::player_t     mario,
    input  goomba_types_pkg::player_t     luigi,
    output goomba_types_pkg::steer_t      steer,
    output goomba_types_pkg::coord_t      goomba_x,
    output goomba_types_pkg::coord_t      goomba_y
);

    goomba_types_pkg::wide_coord_t x_right;
    goomba_types_pkg::wide_coord_t x_far;
    goomba_types_pkg::coord_t      x_left;
    goomba_types_pkg::coord_t      mario_dis;
    goomba_types_pkg::coord_t      luigi_dis;

    ////////////////////////////////////////////////////////////////////////////
    // Position register
    ////////////////////////////////////////////////////////////////////////////

    assign x_right = goomba_types_pkg::wide_coord_t'(goomba_x) +
                     goomba_types_pkg::wide_coord_t'(goomba_cfg_pkg::X_STEP);
    assign x_left  = (goomba_x < goomba_types_pkg::coord_t'(goomba_cfg_pkg::X_STEP)) ? '0 :
                     goomba_x - goomba_types_pkg::coord_t'(goomba_cfg_pkg::X_STEP);

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            goomba_x <= home_x;
        else if (cmd.vanish)
            goomba_x <= '0;
        else if (cmd.move && cmd.left)
            goomba_x <= x_left;
        else if (cmd.move)
            goomba_x <= (x_right >= goomba_types_pkg::wide_coord_t'(x_limit)) ? x_limit :
                        x_right[goomba_cfg_pkg::COORD_W-1:0];
    end

    assign goomba_y = goomba_types_pkg::coord_t'(goomba_cfg_pkg::Y_GROUND);

    ////////////////////////////////////////////////////////////////////////////
    // Edges and chase target
    ////////////////////////////////////////////////////////////////////////////

    assign x_far = goomba_types_pkg::wide_coord_t'(goomba_x) +
                   goomba_types_pkg::wide_coord_t'(goomba_cfg_pkg::SPRITE_SIZE);

    assign steer.at_left_edge  = goomba_x <= scroll;
    assign steer.at_right_edge = x_far >= goomba_types_pkg::wide_coord_t'(x_limit);

    assign mario_dis = (mario.x < goomba_x) ? goomba_x - mario.x : mario.x - goomba_x;
    assign luigi_dis = (luigi.x < goomba_x) ? goomba_x - luigi.x : luigi.x - goomba_x;

    always_comb
    begin
        if (mario.alive && luigi.alive)
        begin
            if (mario_dis >= luigi_dis)                   // Farther player wins and mario takes a tie.
                steer.target_left = mario.x < goomba_x;
            else
                steer.target_left = luigi.x < goomba_x;
        end
        else if (mario.alive)
            steer.target_left = mario.x < goomba_x;
        else if (luigi.alive)
            steer.target_left = luigi.x < goomba_x;
        else
            steer.target_left = 1'b0;
    end

    x_in_range: assert property (@(posedge Clk) disable iff (!arst_n)
        goomba_x <= x_limit);

endmodule

`default_nettype wire

// File: src/goomba_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module goomba_fsm
(
    input  logic                             Clk,
    input  logic                             arst_n,
    input  logic                             frame_tick,
    input  logic                             decide_due,
    input  logic                             death_done,
    input  goomba_types_pkg::steer_t         steer,
    input  logic                             stomped,
    output goomba_types_pkg::move_cmd_t      cmd,
    output logic                             count_clr,
    output goomba_types_pkg::pose_t          pose
);

    goomba_types_pkg::goomba_state_t state;
    goomba_types_pkg::goomba_state_t state_nxt;
    logic heading_left;
    logic phase_one;
    logic left_nxt;

    assign heading_left = (state == goomba_types_pkg::WALK_L1) ||
                          (state == goomba_types_pkg::WALK_L2);
    assign phase_one    = (state == goomba_types_pkg::WALK_L1) ||
                          (state == goomba_types_pkg::WALK_R1);

    ////////////////////////////////////////////////////////////////////////////
    // Next state and move command
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        cmd       = '0;
        count_clr = 1'b0;
        left_nxt  = heading_left;

        if (frame_tick)
        begin
            case (state)
                goomba_types_pkg::DYING:
                begin
                    if (death_done)
                    begin
                        state_nxt  = goomba_types_pkg::GONE;
                        cmd.vanish = 1'b1;
                    end
                end

                goomba_types_pkg::GONE:
                    state_nxt = goomba_types_pkg::GONE;   // Absorbing.

                default:
                begin
                    if (stomped)
                    begin
                        state_nxt = goomba_types_pkg::DYING;
                        count_clr = 1'b1;                 // Start the death timer.
                    end
                    else
                    begin
                        if (steer.at_left_edge)
                            left_nxt = 1'b0;
                        else if (steer.at_right_edge)
                            left_nxt = 1'b1;
                        else if (decide_due)
                        begin
                            left_nxt  = steer.target_left;
                            count_clr = 1'b1;
                        end

                        // Flip the gait phase in the new heading.
                        if (left_nxt)
                            state_nxt = phase_one ? goomba_types_pkg::WALK_L2
                                                  : goomba_types_pkg::WALK_L1;
                        else
                            state_nxt = phase_one ? goomba_types_pkg::WALK_R2
                                                  : goomba_types_pkg::WALK_R1;

                        cmd.move = 1'b1;
                        cmd.left = left_nxt;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= goomba_types_pkg::WALK_L1;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pose
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            goomba_types_pkg::WALK_L1,
            goomba_types_pkg::WALK_R1: pose = goomba_types_pkg::GAIT_A;
            goomba_types_pkg::WALK_L2,
            goomba_types_pkg::WALK_R2: pose = goomba_types_pkg::GAIT_B;
            goomba_types_pkg::DYING:   pose = goomba_types_pkg::SQUASHED;
            default:                   pose = goomba_types_pkg::HIDDEN;
        endcase
    end

    // A squashed or vanished goomba never walks again.
    no_move_dead: assert property (@(posedge Clk) disable iff (!arst_n)
        (state == goomba_types_pkg::DYING || state == goomba_types_pkg::GONE)
        |-> !cmd.move);

endmodule

`default_nettype wire

// File: src/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer
(
    input  logic Clk,
    input  logic arst_n,
    input  logic frame_clk,
    input  logic count_clr,
    output logic frame_tick,
    output logic decide_due,
    output logic death_done
);

    logic sync_q1;
    logic sync_q2;
    logic sync_d;
    goomba_types_pkg::frame_cnt_t frame_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe synchronizer and edge detect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_q1    <= 1'b0;
            sync_q2    <= 1'b0;
            sync_d     <= 1'b0;
            frame_tick <= 1'b0;
        end
        else
        begin
            sync_q1    <= frame_clk;
            sync_q2    <= sync_q1;
            sync_d     <= sync_q2;                        // Previous synchronized level.
            frame_tick <= sync_q2 && !sync_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            frame_cnt <= '0;
        else if (count_clr)
            frame_cnt <= '0;                              // Clear wins over a tick.
        else if (frame_tick &&
                 frame_cnt != goomba_types_pkg::frame_cnt_t'(goomba_cfg_pkg::COUNT_MAX))
            frame_cnt <= frame_cnt + goomba_types_pkg::frame_cnt_t'(1);
    end

    assign decide_due =
        frame_cnt >= goomba_types_pkg::frame_cnt_t'(goomba_cfg_pkg::DECIDE_FRAMES);
    assign death_done =
        frame_cnt >= goomba_types_pkg::frame_cnt_t'(goomba_cfg_pkg::DEATH_FRAMES);

    // A frame strobe never yields back-to-back ticks.
    tick_single: assert property (@(posedge Clk) disable iff (!arst_n)
        frame_tick |=> !frame_tick);

endmodule

`default_nettype wire

// File: src/goomba_types_pkg.sv
`default_nettype none

package goomba_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Scalar words
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [goomba_cfg_pkg::COORD_W-1:0] coord_t;
    typedef logic [goomba_cfg_pkg::COORD_W:0]   wide_coord_t;  // One carry bit for sums.
    typedef logic [goomba_cfg_pkg::PIXEL_W-1:0] pixel_t;
    typedef logic [goomba_cfg_pkg::COUNT_W-1:0] frame_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   alive;
        coord_t x;
    } player_t;

    typedef struct packed {
        pixel_t walk_a;
        pixel_t walk_b;
        pixel_t squashed;
    } sprite_art_t;

    typedef struct packed {
        logic move;                                       // Step this cycle.
        logic left;                                       // Step direction.
        logic vanish;                                     // Park at x = 0.
    } move_cmd_t;

    typedef struct packed {
        logic at_left_edge;
        logic at_right_edge;
        logic target_left;                                // Chased player lies left.
    } steer_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        WALK_L1,
        WALK_L2,
        WALK_R1,
        WALK_R2,
        DYING,
        GONE
    } goomba_state_t;

    typedef enum logic [1:0] {
        GAIT_A,
        GAIT_B,
        SQUASHED,
        HIDDEN
    } pose_t;

endpackage

`default_nettype wire

// File: src/goomba_cfg_pkg.sv
`default_nettype none

package goomba_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Screen and sprite geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned COORD_W     = 10;             // Screen coordinate bits.
    localparam int unsigned PIXEL_W     = 24;             // RGB, 8 bits per channel.
    localparam int unsigned SPRITE_SIZE = 32;             // Square sprite side.
    localparam int unsigned Y_GROUND    = 384;            // Ground line under the feet.
    localparam int unsigned X_STEP      = 2;              // Pixels per frame tick.

    ////////////////////////////////////////////////////////////////////////////
    // Frame timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned DECIDE_FRAMES = 4;            // Ticks between chase decisions.
    localparam int unsigned DEATH_FRAMES  = 4;            // Ticks the squashed sprite shows.

    // The frame counter stops at whichever threshold is larger.
    localparam int unsigned COUNT_MAX =
        (DECIDE_FRAMES > DEATH_FRAMES) ? DECIDE_FRAMES : DEATH_FRAMES;
    localparam int unsigned COUNT_W   = $clog2(COUNT_MAX + 1);

    ////////////////////////////////////////////////////////////////////////////
    // Colours
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [PIXEL_W-1:0] SKY_COLOR = 24'h6b8cff;  // Level background.

endpackage

`default_nettype wire
